//--- logic/ecc_mem_defines.svh
`ifndef ECC_MEM_DEFINES_SVH
`define ECC_MEM_DEFINES_SVH

// Datapath sizes.
`define ECC_MEM_DATA_W      32
`define ECC_MEM_CODE_W      39
`define ECC_MEM_ADDR_W      10
`define ECC_MEM_ROW_W       8
`define ECC_MEM_WORDS       4
`define ECC_MEM_WORD_SEL_W  2
`define ECC_MEM_PORTS       2

// Cycles from the read sample edge until the row is available.
`define ECC_MEM_SRAM_DELAY  2

// APB register offsets.
`define ECC_MEM_INJ_OFFSET  12'h000
`define ECC_MEM_CNT_OFFSET  12'h004

`endif

//--- logic/ecc_mem_pkg.sv
`include "ecc_mem_defines.svh"

package ecc_mem_pkg;

  typedef struct packed {
    logic                        en;
    logic [`ECC_MEM_ADDR_W-1:0]  addr;
    logic [`ECC_MEM_DATA_W-1:0]  data;
  } wr_req_t;

  typedef struct packed {
    logic                            en;
    logic [`ECC_MEM_ROW_W-1:0]       row;
    logic [`ECC_MEM_WORD_SEL_W-1:0]  word;
    logic [`ECC_MEM_CODE_W-1:0]      code;
  } wr_code_t;

  typedef struct packed {
    logic                        en;
    logic [`ECC_MEM_ADDR_W-1:0]  addr;
  } rd_req_t;

  typedef struct packed {
    logic                            valid;
    logic [`ECC_MEM_WORD_SEL_W-1:0]  word;
  } rd_meta_t;

  typedef logic [`ECC_MEM_WORDS-1:0][`ECC_MEM_CODE_W-1:0] row_t;

  typedef struct packed {
    logic                        valid;
    logic [`ECC_MEM_DATA_W-1:0]  data;
    logic                        serr;
    logic                        derr;
  } rd_resp_t;

  // Hamming position of data bit idx. Powers of two are left for check bits.
  function automatic logic [5:0] data_pos(input int idx);
    int cnt;
    data_pos = '0;
    cnt = 0;
    for (int p = 3; p < `ECC_MEM_CODE_W; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (cnt == idx) data_pos = 6'(p);
        cnt++;
      end
    end
  endfunction

  // Each check bit covers the positions with its bit set, so the XOR of all
  // set positions gives the whole check vector at once.
  function automatic logic [5:0] hamming_check(input logic [`ECC_MEM_DATA_W-1:0] data);
    logic [5:0] chk;
    chk = '0;
    for (int i = 0; i < `ECC_MEM_DATA_W; i++) begin
      if (data[i]) chk = chk ^ data_pos(i);
    end
    return chk;
  endfunction

endpackage

//--- logic/ecc_apb_pkg.sv
`include "ecc_mem_defines.svh"

package ecc_apb_pkg;

  typedef struct packed {
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [11:0]                 paddr;
    logic [`ECC_MEM_DATA_W-1:0]  pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`ECC_MEM_DATA_W-1:0]  prdata;
    logic                        pready;
    logic                        pslverr;
  } apb_resp_t;

  // Register image is the struct itself in pwdata[13:0], enable at bit 13.
  typedef struct packed {
    logic        enable;
    logic [5:0]  pos1;
    logic        pos2_en;
    logic [5:0]  pos2;
  } inj_cfg_t;

endpackage

//--- logic/delay_pipe.sv
`timescale 1ns/1ps
`include "ecc_mem_defines.svh"

module delay_pipe #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = `ECC_MEM_SRAM_DELAY - 1
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t din,
  output payload_t dout
);

  payload_t stage [DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign dout = stage[DEPTH-1];

endmodule

//--- logic/secded_encoder.sv
`timescale 1ns/1ps
`include "ecc_mem_defines.svh"

module secded_encoder
  import ecc_mem_pkg::*;
(
  input  wr_req_t  wr,
  output wr_code_t code
);

  logic [5:0]                 check;
  logic                       parity;
  logic [`ECC_MEM_DATA_W-1:0] data;

  assign data = wr.data;
  assign check = hamming_check(data);
  assign parity = ^{check, data};  // Makes the whole codeword even.

  always_comb begin
    code.en   = wr.en;
    code.row  = wr.addr[`ECC_MEM_ADDR_W-1:`ECC_MEM_WORD_SEL_W];
    code.word = wr.addr[`ECC_MEM_WORD_SEL_W-1:0];
    // Data sits low so a clean read needs no unpacking.
    code.code = {parity, check, data};
  end

endmodule

//--- logic/secded_decoder.sv
`timescale 1ns/1ps
`include "ecc_mem_defines.svh"

module secded_decoder
  import ecc_mem_pkg::*, ecc_apb_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`ECC_MEM_CODE_W-1:0] code,
  input  rd_meta_t                   meta,
  input  inj_cfg_t                   inj,
  output rd_resp_t                   resp
);

  localparam logic [`ECC_MEM_CODE_W-1:0] BIT0 = 1;

  logic [`ECC_MEM_CODE_W-1:0] mask;
  logic [`ECC_MEM_CODE_W-1:0] word;
  logic [5:0]                 syndrome;
  logic                       odd;
  logic [`ECC_MEM_DATA_W-1:0] fixed;
  logic                       serr;
  logic                       derr;

  always_comb begin
    mask = '0;
    if (inj.enable) begin
      mask = BIT0 << inj.pos1;
      if (inj.pos2_en) mask = mask ^ (BIT0 << inj.pos2);
    end
  end

  assign word = code ^ mask;
  assign syndrome = hamming_check(word[`ECC_MEM_DATA_W-1:0]) ^
                    word[`ECC_MEM_DATA_W+5:`ECC_MEM_DATA_W];
  assign odd = ^word;

  // A syndrome pointing at a check bit leaves the data alone.
  always_comb begin
    fixed = word[`ECC_MEM_DATA_W-1:0];
    if (syndrome != '0 && odd) begin
      for (int i = 0; i < `ECC_MEM_DATA_W; i++) begin
        if (data_pos(i) == syndrome) fixed[i] = ~fixed[i];
      end
    end
  end

  assign serr = odd;                      // Covers the lone parity bit error too.
  assign derr = (syndrome != '0) && !odd;

  always_ff @(posedge clk) begin
    if (rst) begin
      resp.valid <= 1'b0;
      resp.serr  <= 1'b0;
      resp.derr  <= 1'b0;
    end else begin
      resp.valid <= meta.valid;
      resp.serr  <= meta.valid & serr;
      resp.derr  <= meta.valid & derr;
    end
  end

  always_ff @(posedge clk) begin
    resp.data <= fixed;
  end

endmodule

//--- logic/aligned_row_store.sv
`timescale 1ns/1ps
`include "ecc_mem_defines.svh"

module aligned_row_store
  import ecc_mem_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  wr_code_t                   wr   [`ECC_MEM_PORTS],
  input  rd_req_t                    rd   [`ECC_MEM_PORTS],
  output logic [`ECC_MEM_CODE_W-1:0] code [`ECC_MEM_PORTS],
  output rd_meta_t                   meta [`ECC_MEM_PORTS]
);

  localparam int ROWS = 2 ** `ECC_MEM_ROW_W;

  row_t mem [ROWS];

  // Port 1 is applied last, so it wins a same-word collision.
  always_ff @(posedge clk) begin
    for (int p = 0; p < `ECC_MEM_PORTS; p++) begin
      if (wr[p].en) begin
        mem[wr[p].row][wr[p].word] <= wr[p].code;
      end
    end
  end

  for (genvar p = 0; p < `ECC_MEM_PORTS; p++) begin : g_rd
    row_t     row_q;
    row_t     row_d;
    rd_meta_t meta_q;
    rd_meta_t meta_d;

    // Nonblocking reads see the row before any write at the same edge.
    always_ff @(posedge clk) begin
      if (rd[p].en) begin
        row_q <= mem[rd[p].addr[`ECC_MEM_ADDR_W-1:`ECC_MEM_WORD_SEL_W]];
      end
    end

    always_ff @(posedge clk) begin
      if (rst) begin
        meta_q <= '0;
      end else begin
        meta_q.valid <= rd[p].en;
        meta_q.word  <= rd[p].addr[`ECC_MEM_WORD_SEL_W-1:0];
      end
    end

    delay_pipe #(
      .payload_t (row_t),
      .DEPTH     (`ECC_MEM_SRAM_DELAY - 1)
    ) u_row_pipe (
      .clk  (clk),
      .rst  (rst),
      .din  (row_q),
      .dout (row_d)
    );

    delay_pipe #(
      .payload_t (rd_meta_t),
      .DEPTH     (`ECC_MEM_SRAM_DELAY - 1)
    ) u_meta_pipe (
      .clk  (clk),
      .rst  (rst),
      .din  (meta_q),
      .dout (meta_d)
    );

    assign code[p] = row_d[meta_d.word];
    assign meta[p] = meta_d;
  end

endmodule

//--- logic/ecc_csr_apb.sv
`timescale 1ns/1ps
`include "ecc_mem_defines.svh"

module ecc_csr_apb
  import ecc_mem_pkg::*, ecc_apb_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  apb_req_t  apb_req,
  output apb_resp_t apb_resp,
  input  rd_resp_t  resp [`ECC_MEM_PORTS],
  output inj_cfg_t  inj
);

  logic        access;
  logic        hit_inj;
  logic        hit_cnt;
  logic [15:0] serr_cnt;
  logic [15:0] derr_cnt;
  logic [1:0]  serr_inc;
  logic [1:0]  derr_inc;

  function automatic logic [15:0] sat_add(input logic [15:0] cnt, input logic [1:0] inc);
    logic [16:0] sum;
    sum = {1'b0, cnt} + {15'b0, inc};
    return sum[16] ? 16'hffff : sum[15:0];
  endfunction

  assign access  = apb_req.psel && apb_req.penable;
  assign hit_inj = apb_req.paddr == `ECC_MEM_INJ_OFFSET;
  assign hit_cnt = apb_req.paddr == `ECC_MEM_CNT_OFFSET;

  // Both ports can flag in one cycle.
  always_comb begin
    serr_inc = '0;
    derr_inc = '0;
    for (int p = 0; p < `ECC_MEM_PORTS; p++) begin
      serr_inc = serr_inc + 2'(resp[p].valid & resp[p].serr);
      derr_inc = derr_inc + 2'(resp[p].valid & resp[p].derr);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      inj <= '0;
    end else if (access && apb_req.pwrite && hit_inj) begin
      inj <= inj_cfg_t'(apb_req.pwdata[$bits(inj_cfg_t)-1:0]);
    end
  end

  // Any write to the counter register clears both counts.
  always_ff @(posedge clk) begin
    if (rst) begin
      serr_cnt <= '0;
      derr_cnt <= '0;
    end else if (access && apb_req.pwrite && hit_cnt) begin
      serr_cnt <= '0;
      derr_cnt <= '0;
    end else begin
      serr_cnt <= sat_add(serr_cnt, serr_inc);
      derr_cnt <= sat_add(derr_cnt, derr_inc);
    end
  end

  always_comb begin
    apb_resp.pready  = 1'b1;                  // No wait states.
    apb_resp.pslverr = access && !hit_inj && !hit_cnt;
    apb_resp.prdata  = '0;
    if (hit_inj) begin
      apb_resp.prdata = {{(`ECC_MEM_DATA_W - $bits(inj_cfg_t)){1'b0}}, inj};
    end else if (hit_cnt) begin
      apb_resp.prdata = {derr_cnt, serr_cnt};
    end
  end

endmodule

//--- logic/ecc_mem_top.sv
`timescale 1ns/1ps
`include "ecc_mem_defines.svh"

module ecc_mem_top
  import ecc_mem_pkg::*, ecc_apb_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  wr_req_t   wr_req  [`ECC_MEM_PORTS],
  input  rd_req_t   rd_req  [`ECC_MEM_PORTS],
  output rd_resp_t  rd_resp [`ECC_MEM_PORTS],
  input  apb_req_t  apb_req,
  output apb_resp_t apb_resp
);

  wr_code_t                   wr_code  [`ECC_MEM_PORTS];
  logic [`ECC_MEM_CODE_W-1:0] rd_code  [`ECC_MEM_PORTS];
  rd_meta_t                   rd_meta  [`ECC_MEM_PORTS];
  inj_cfg_t                   inj_cfg;

  for (genvar p = 0; p < `ECC_MEM_PORTS; p++) begin : g_enc
    secded_encoder u_enc (
      .wr   (wr_req[p]),
      .code (wr_code[p])
    );
  end

  aligned_row_store u_store (
    .clk  (clk),
    .rst  (rst),
    .wr   (wr_code),
    .rd   (rd_req),
    .code (rd_code),
    .meta (rd_meta)
  );

  // Both decoders share one injection setting.
  for (genvar p = 0; p < `ECC_MEM_PORTS; p++) begin : g_dec
    secded_decoder u_dec (
      .clk  (clk),
      .rst  (rst),
      .code (rd_code[p]),
      .meta (rd_meta[p]),
      .inj  (inj_cfg),
      .resp (rd_resp[p])
    );
  end

  ecc_csr_apb u_csr (
    .clk      (clk),
    .rst      (rst),
    .apb_req  (apb_req),
    .apb_resp (apb_resp),
    .resp     (rd_resp),   // Counters watch the same responses the ports see.
    .inj      (inj_cfg)
  );

endmodule

//--- verification/ecc_mem_assertions.sv
`timescale 1ns/1ps
`include "ecc_mem_defines.svh"

module ecc_mem_assertions
  import ecc_mem_pkg::*, ecc_apb_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input rd_req_t   rd_req  [`ECC_MEM_PORTS],
  input rd_resp_t  rd_resp [`ECC_MEM_PORTS],
  input apb_req_t  apb_req,
  input apb_resp_t apb_resp
);

  localparam int LAT = `ECC_MEM_SRAM_DELAY + 1;

  int fails = 0;

  for (genvar p = 0; p < `ECC_MEM_PORTS; p++) begin : g_port
    // A read sampled at one edge is seen as a valid LAT edges later.
    assert property (@(posedge clk) disable iff (rst)
      rd_resp[p].valid |-> $past(rd_req[p].en, LAT))
    else begin
      fails = fails + 1;
      $error("response on port %0d has no read %0d cycles before it", p, LAT);
    end

    assert property (@(posedge clk) disable iff (rst) !(rd_resp[p].serr && rd_resp[p].derr))
    else begin
      fails = fails + 1;
      $error("serr and derr both high on port %0d", p);
    end
  end

  assert property (@(posedge clk) disable iff (rst) apb_req.psel |-> apb_resp.pready)
  else begin
    fails = fails + 1;
    $error("pready low while psel is high");
  end

endmodule

bind ecc_mem_top ecc_mem_assertions u_assert (.*);

//--- verification/ecc_mem_tb.sv
`timescale 1ns/1ps
`include "ecc_mem_defines.svh"

module ecc_mem_tb
  import ecc_mem_pkg::*, ecc_apb_pkg::*;
();

  localparam int PERIOD     = 40;
  localparam int RST_CYCLES = 16;
  localparam int RD_LAT     = `ECC_MEM_SRAM_DELAY + 1;

  typedef struct {
    logic [23:0]  op;
    logic         shared;
    int           port;
    logic [11:0]  addr;
    logic [31:0]  data;
    logic [31:0]  exp;
    logic         serr;
    logic         derr;
    logic [127:0] name;
  } line_t;

  logic      clk;
  logic      rst;
  wr_req_t   wr_req  [`ECC_MEM_PORTS];
  rd_req_t   rd_req  [`ECC_MEM_PORTS];
  rd_resp_t  rd_resp [`ECC_MEM_PORTS];
  apb_req_t  apb_req;
  apb_resp_t apb_resp;

  line_t lines [$];
  line_t pend  [$];  // Outstanding reads. Their exp field holds the due step.
  int    steps  = 0;
  int    cycles = 0;
  int    limit  = 100000;
  int    passed = 0;
  int    failed = 0;

  ecc_mem_top DUT (
    .clk      (clk),
    .rst      (rst),
    .wr_req   (wr_req),
    .rd_req   (rd_req),
    .rd_resp  (rd_resp),
    .apb_req  (apb_req),
    .apb_resp (apb_resp)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("timeout after %0d cycles with %0d reads unanswered", cycles, pend.size());
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic clear_inputs();
    for (int p = 0; p < `ECC_MEM_PORTS; p++) begin
      wr_req[p] = '0;
      rd_req[p] = '0;
    end
    apb_req = '0;
  endtask

  task automatic note_pass(input logic [127:0] name);
    passed++;
    $display("ok %0s", name);
  endtask

  task automatic check_due();
    line_t  e;
    rd_resp_t r;
    while (pend.size() > 0 && pend[0].exp <= steps) begin
      e = pend.pop_front();
      r = rd_resp[e.port];
      if (!r.valid) begin
        failed++;
        $display("%0s: no valid response on port %0d after the read", e.name, e.port);
      end else if (r.data !== e.data) begin
        failed++;
        $display("mismatch %0s: expected %h, actual %h", e.name, e.data, r.data);
      end else if (r.serr !== e.serr || r.derr !== e.derr) begin
        failed++;
        $display("mismatch %0s: expected serr/derr %b%b, actual %b%b",
                 e.name, e.serr, e.derr, r.serr, r.derr);
      end else begin
        note_pass(e.name);
      end
    end
  endtask

  // Every step is one falling edge; answers due there are checked first.
  task automatic step();
    @(negedge clk);
    steps++;
    check_due();
    clear_inputs();
  endtask

  task automatic drive_port(input line_t l);
    line_t e;
    if (l.op == "WR") begin
      wr_req[l.port] = '{en: 1'b1, addr: l.addr[9:0], data: l.data};
    end else begin
      rd_req[l.port] = '{en: 1'b1, addr: l.addr[9:0]};
      e = l;
      e.data = l.exp;
      e.exp = steps + RD_LAT;  // Three rising edges later the answer is on the port.
      pend.push_back(e);
    end
  endtask

  task automatic drive_apb(input line_t l);
    apb_req_t req;
    req = '{psel: 1'b1, penable: 1'b0, pwrite: l.op == "AW", paddr: l.addr, pwdata: l.data};
    step();
    apb_req = req;
    step();
    req.penable = 1'b1;
    apb_req = req;
    #(PERIOD / 4);
    if (l.op == "AR" && apb_resp.prdata !== l.exp) begin
      failed++;
      $display("mismatch %0s: expected %h, actual %h", l.name, l.exp, apb_resp.prdata);
    end else if (apb_resp.pslverr !== l.serr) begin
      failed++;
      $display("mismatch %0s: expected pslverr %b, actual %b", l.name, l.serr, apb_resp.pslverr);
    end else begin
      note_pass(l.name);
    end
  endtask

  task automatic load_lines();
    int          fd;
    int          n;
    string       text;
    logic [23:0] op;
    line_t       l;
    fd = $fopen("verification/ecc_mem_testdata.txt", "r");
    if (fd == 0) begin
      failed++;
      $display("could not open verification/ecc_mem_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        text = "";
        n = $fgets(text, fd);
        if (n > 0 && text[0] != "#") begin
          n = $sscanf(text, "%s %h %h %h %h %h %h %s", op, l.port, l.addr, l.data,
                      l.exp, l.serr, l.derr, l.name);
          if (n == 8) begin
            l.shared = op[7:0] == "+";
            l.op = l.shared ? op >> 8 : op;
            lines.push_back(l);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    logic prev_shared;
    rst = 1'b1;
    clear_inputs();
    load_lines();
    limit = RST_CYCLES + 6 * lines.size() + 50;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    prev_shared = 1'b0;
    foreach (lines[i]) begin
      if (lines[i].op == "WR" || lines[i].op == "RD") begin
        if (!prev_shared) step();
        drive_port(lines[i]);
        prev_shared = lines[i].shared;
      end else begin
        if (lines[i].op == "ID") repeat (lines[i].data) step();
        else drive_apb(lines[i]);
        prev_shared = 1'b0;
      end
    end
    while (pend.size() > 0) step();
    step();
    $display("%0d passed, %0d failed, %0d assertion failures",
             passed, failed, DUT.u_assert.fails);
    if (failed == 0 && DUT.u_assert.fails == 0 && passed > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- verification/ecc_mem_testdata.txt
# Columns: op port addr data exp_data exp_serr exp_derr name, all numbers hex.
# WR+/RD+ share the cycle with the next line, AW/AR are APB (pslverr in serr), ID idles data cycles.
WR  0 004 12345678 0        0 0 wr_p0
RD  0 004 0        12345678 0 0 rd_p0
WR  1 3fc cafef00d 0        0 0 wr_p1
RD  1 3fc 0        cafef00d 0 0 rd_p1
WR+ 0 100 a0a0a0a0 0        0 0 pack_w0
WR  1 101 b1b1b1b1 0        0 0 pack_w1
WR+ 0 102 c2c2c2c2 0        0 0 pack_w2
WR  1 103 d3d3d3d3 0        0 0 pack_w3
RD+ 0 100 0        a0a0a0a0 0 0 pack_r0
RD  1 101 0        b1b1b1b1 0 0 pack_r1
RD+ 0 102 0        c2c2c2c2 0 0 pack_r2
RD  1 103 0        d3d3d3d3 0 0 pack_r3
WR  0 020 11111111 0        0 0 coll_init
WR+ 0 020 22222222 0        0 0 coll_w0
WR+ 1 020 33333333 0        0 0 coll_w1
RD  0 020 0        11111111 0 0 coll_old
RD  1 020 0        33333333 0 0 coll_new
ID  0 000 4        0        0 0 drain_a
AW  0 000 2280     0        0 0 inj_single
RD  0 004 0        12345678 1 0 single_r0
RD  1 3fc 0        cafef00d 1 0 single_r1
ID  0 000 4        0        0 0 drain_b
AR  0 004 0        2        0 0 serr_count
AW  0 000 21c9     0        0 0 inj_double
RD  0 100 0        a0a0a2a8 0 1 double_r0
ID  0 000 4        0        0 0 drain_c
AR  0 004 0        10002    0 0 both_count
AW  0 004 0        0        0 0 cnt_clear
AR  0 004 0        0        0 0 cnt_zero
AW  0 000 280      0        0 0 inj_off
AW  0 008 ffffffff 0        1 0 bad_wr
AR  0 008 0        0        1 0 bad_rd
AR  0 000 0        280      0 0 inj_kept

//--- ecc_mem.f
+incdir+logic
logic/ecc_mem_pkg.sv
logic/ecc_apb_pkg.sv
logic/delay_pipe.sv
logic/secded_encoder.sv
logic/secded_decoder.sv
logic/aligned_row_store.sv
logic/ecc_csr_apb.sv
logic/ecc_mem_top.sv
verification/ecc_mem_assertions.sv
verification/ecc_mem_tb.sv

//--- Bender.yml
package:
  name: ecc_mem

sources:
  - include_dirs:
      - logic
    files:
      - logic/ecc_mem_pkg.sv
      - logic/ecc_apb_pkg.sv
      - logic/delay_pipe.sv
      - logic/secded_encoder.sv
      - logic/secded_decoder.sv
      - logic/aligned_row_store.sv
      - logic/ecc_csr_apb.sv
      - logic/ecc_mem_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verification/ecc_mem_assertions.sv
      - verification/ecc_mem_tb.sv
